/* cmd_decoder.sv */
`timescale 1ns/1ps

module cmd_decoder #(
  parameter int REG_COUNT = 8
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 rx_valid,
  input  logic [7:0]           rx_byte,
  output logic                 cmd_valid,
  output serial_cmd_pkg::cmd_t cmd,
  output logic                 addr_err
);

  import serial_cmd_pkg::*;

  localparam logic [8:0] ADDR_LIMIT = 9'(REG_COUNT);

  typedef enum logic [1:0] {
    s_wait_op,
    s_wait_addr,
    s_wait_data
  } state_t;

  state_t state;
  op_t    op_in;

  function automatic logic out_of_range(input logic [7:0] addr);
    return ({1'b0, addr} >= ADDR_LIMIT);
  endfunction

  always_comb begin
    if (rx_byte == BYTE_WRITE) begin
      op_in = op_write;
    end else if (rx_byte == BYTE_READ) begin
      op_in = op_read;
    end else begin
      op_in = op_bad_op;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= s_wait_op;
      cmd_valid <= 1'b0;
      addr_err  <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      addr_err  <= 1'b0;
      if (rx_valid) begin
        case (state)
          s_wait_op: begin
            if (op_in == op_bad_op) begin
              cmd_valid <= 1'b1;  // Unknown byte is reported right away.
            end else begin
              state <= s_wait_addr;
            end
          end
          s_wait_addr: begin
            if (cmd.op == op_read) begin
              cmd_valid <= 1'b1;
              addr_err  <= out_of_range(rx_byte);
              state     <= s_wait_op;
            end else begin
              state <= s_wait_data;
            end
          end
          default: begin
            cmd_valid <= 1'b1;
            addr_err  <= out_of_range(cmd.addr);  // Checked after the data byte.
            state     <= s_wait_op;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid) begin
      case (state)
        s_wait_op:   cmd.op   <= op_in;
        s_wait_addr: cmd.addr <= rx_byte;
        default:     cmd.data <= rx_byte;
      endcase
    end
  end

endmodule

/* list.f */
serial_cmd_pkg.sv
uart_rx.sv
cmd_decoder.sv
reg_file_exec.sv
resp_builder.sv
uart_tx.sv
serial_cmd_top.sv
serial_cmd_sva.sv
serial_cmd_tb.sv

/* reg_file_exec.sv */
`timescale 1ns/1ps

module reg_file_exec #(
  parameter int REG_COUNT = 8
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cmd_valid,
  input  serial_cmd_pkg::cmd_t    cmd,
  input  logic                    addr_err,
  output logic                    result_valid,
  output serial_cmd_pkg::result_t result,
  output logic [7:0]              leds
);

  import serial_cmd_pkg::*;

  localparam int AW = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

  logic [7:0]    regs [REG_COUNT];
  logic [AW-1:0] idx;

  assign idx  = cmd.addr[AW-1:0];  // Upper bits are zero once the decoder passes the address.
  assign leds = regs[0];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
      result_valid <= 1'b0;
    end else begin
      result_valid <= cmd_valid;
      if (cmd_valid && !addr_err && cmd.op == op_write) begin
        regs[idx] <= cmd.data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      if (addr_err) begin
        result.kind <= res_bad_addr;
        result.data <= cmd.addr;
      end else begin
        case (cmd.op)
          op_write: begin
            result.kind <= res_ok;
            result.data <= cmd.data;
          end
          op_read: begin
            result.kind <= res_read_data;
            result.data <= regs[idx];
          end
          default: begin
            result.kind <= res_bad_op;
            result.data <= '0;
          end
        endcase
      end
    end
  end

endmodule

/* resp_builder.sv */
`timescale 1ns/1ps

module resp_builder (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    result_valid,
  input  serial_cmd_pkg::result_t result,
  input  logic                    tx_busy,
  output logic                    tx_start,
  output logic [7:0]              tx_byte
);

  import serial_cmd_pkg::*;

  logic       pending;
  logic [7:0] reply_q;

  function automatic logic [7:0] reply_byte(input result_t res);
    case (res.kind)
      res_ok:        return REPLY_OK;
      res_read_data: return res.data;
      res_bad_op:    return REPLY_BAD_OP;
      default:       return REPLY_BAD_ADDR;
    endcase
  endfunction

  assign tx_start = pending && !tx_busy;  // Fires on the first idle cycle of the transmitter.
  assign tx_byte  = reply_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (tx_start) begin
      pending <= 1'b0;
    end else if (result_valid) begin
      pending <= 1'b1;  // A result arriving while one waits is lost.
    end
  end

  always_ff @(posedge clk) begin
    if (result_valid && !pending) begin
      reply_q <= reply_byte(result);
    end
  end

endmodule

/* serial_cmd_input.txt */
# name kind nbytes byte0 byte1 byte2 expected (hex bytes)
# kind cmd checks the reply, leds checks the K reply and then leds, glitch expects no reply
rd_reset_a0 cmd 2 52 00 00 00
rd_reset_a7 cmd 2 52 07 00 00
leds_reset leds 0 00 00 00 00
wr_a3 cmd 3 57 03 a5 4b
wr_a5 cmd 3 57 05 3c 4b
rd_a3 cmd 2 52 03 00 a5
rd_a5 cmd 2 52 05 00 3c
wr_leds leds 3 57 00 81 81
rd_a0 cmd 2 52 00 00 81
bad_opcode cmd 1 41 00 00 3f
rd_after_bad_op cmd 2 52 03 00 a5
wr_bad_addr cmd 3 57 08 ff 45
rd_bad_addr cmd 2 52 20 00 45
rd_a7_unchanged cmd 2 52 07 00 00
short_glitch glitch 0 00 00 00 00
rd_after_glitch cmd 2 52 05 00 3c

/* serial_cmd_pkg.sv */
package serial_cmd_pkg;

  typedef enum logic [1:0] {
    op_write,
    op_read,
    op_bad_op
  } op_t;

  localparam logic [7:0] BYTE_WRITE = 8'h57;  // ASCII W starts a write.
  localparam logic [7:0] BYTE_READ  = 8'h52;  // ASCII R starts a read.

  localparam logic [7:0] REPLY_OK       = 8'h4b;  // ASCII K.
  localparam logic [7:0] REPLY_BAD_OP   = 8'h3f;  // ASCII question mark.
  localparam logic [7:0] REPLY_BAD_ADDR = 8'h45;  // ASCII E.

  typedef struct packed {
    op_t        op;
    logic [7:0] addr;
    logic [7:0] data;
  } cmd_t;

  typedef enum logic [1:0] {
    res_ok,
    res_read_data,
    res_bad_op,
    res_bad_addr
  } res_kind_t;

  typedef struct packed {
    res_kind_t  kind;
    logic [7:0] data;  // Register value for a read, otherwise informational.
  } result_t;

endpackage

/* serial_cmd_sva.sv */
`timescale 1ns/1ps

module serial_cmd_sva (
  input logic clk,
  input logic reset,
  input logic rx_valid,
  input logic cmd_valid,
  input logic tx_start,
  input logic result_valid,
  input logic pending,
  input logic tx,
  input logic tx_busy
);

  int assert_fails = 0;  // Read by the testbench at the end of the run.

  a_rx_pulse: assert property (@(posedge clk) disable iff (reset) rx_valid |=> !rx_valid)
    else begin
      $error("rx_valid was high for more than one cycle");
      assert_fails++;
    end

  a_cmd_pulse: assert property (@(posedge clk) disable iff (reset) cmd_valid |=> !cmd_valid)
    else begin
      $error("cmd_valid was high for more than one cycle");
      assert_fails++;
    end

  a_start_pulse: assert property (@(posedge clk) disable iff (reset) tx_start |=> !tx_start)
    else begin
      $error("tx_start was high for more than one cycle");
      assert_fails++;
    end

  // A second result while one waits would be lost by the reply stage.
  a_no_overrun: assert property (@(posedge clk) disable iff (reset) result_valid |-> !pending)
    else begin
      $error("result_valid arrived while a reply was still pending");
      assert_fails++;
    end

  a_tx_idle: assert property (@(posedge clk) disable iff (reset) !tx_busy |-> tx)
    else begin
      $error("tx was low while the transmitter was idle");
      assert_fails++;
    end

endmodule

bind serial_cmd_top serial_cmd_sva u_sva (
  .clk         (clk),
  .reset       (reset),
  .rx_valid    (rx_valid),
  .cmd_valid   (cmd_valid),
  .tx_start    (tx_start),
  .result_valid(result_valid),
  .pending     (u_resp.pending),
  .tx          (tx),
  .tx_busy     (tx_busy)
);

/* serial_cmd_tb.sv */
`timescale 1ns/1ps

module serial_cmd_tb;

  localparam int BIT_CLKS = 100;  // 100 MHz clock at 1 Mbaud.
  localparam int REPLY_WAIT = 30 * BIT_CLKS;
  localparam int GLITCH_CLKS = 30;  // Well under half a bit.
  localparam logic [7:0] ACK = "K";
  localparam logic [7:0] WRITE_OP = "W";

  logic clk;
  logic reset;
  logic rx;
  logic tx;
  logic [7:0] leds;

  string      t_name[$];
  string      t_kind[$];
  int         t_len[$];
  logic [7:0] t_bytes[$];  // Three entries per test.
  logic [7:0] t_exp[$];
  int         pass_count;
  int         fail_count;
  bit         loaded;
  logic [7:0] reg0_model;  // Register 0 as the host expects it, seen on leds.

  serial_cmd_top #(
    .BAUD_RATE(1_000_000)
  ) uut (
    .clk  (clk),
    .reset(reset),
    .rx   (rx),
    .tx   (tx),
    .leds (leds)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic send_byte(input logic [7:0] b);
    rx = 1'b0;
    wait_cycles(BIT_CLKS);
    for (int i = 0; i < 8; i++) begin
      rx = b[i];
      wait_cycles(BIT_CLKS);
    end
    rx = 1'b1;
    wait_cycles(BIT_CLKS);
  endtask

  task automatic idle_gap();
    int n;
    n = $urandom % (3 * BIT_CLKS + 1);
    if (n > 0) begin
      wait_cycles(n);
    end
  endtask

  // Samples each bit of the reply at its middle.
  task automatic get_reply(output logic [7:0] data, output bit got, output bit framed);
    int waited;
    waited = 0;
    data = '0;
    got = 1'b0;
    framed = 1'b0;
    while (tx && waited < REPLY_WAIT) begin
      wait_cycles(1);
      waited++;
    end
    if (!tx) begin
      got = 1'b1;
      wait_cycles(BIT_CLKS / 2);
      framed = !tx;
      for (int i = 0; i < 8; i++) begin
        wait_cycles(BIT_CLKS);
        data[i] = tx;
      end
      wait_cycles(BIT_CLKS);
      framed = framed && tx;
    end
  endtask

  task automatic record_pass(input string name);
    $display("ok      %s", name);
    pass_count++;
  endtask

  task automatic record_mismatch(input string name, input logic [7:0] exp, input logic [7:0] act);
    $display("FAILED %s: expected %h, actual %h", name, exp, act);
    fail_count++;
  endtask

  task automatic record_problem(input string name, input string what);
    $display("test %s: %s", name, what);
    fail_count++;
  endtask

  task automatic run_test(input int t);
    logic [7:0] reply;
    bit         got;
    bit         framed;
    reply = '0;
    got = 1'b0;
    framed = 1'b0;
    if (t_kind[t] == "glitch") begin
      rx = 1'b0;
      wait_cycles(GLITCH_CLKS);
      rx = 1'b1;
      get_reply(reply, got, framed);
    end else if (t_len[t] > 0) begin
      for (int k = 0; k < t_len[t] - 1; k++) begin
        send_byte(t_bytes[3 * t + k]);
        idle_gap();
      end
      fork
        send_byte(t_bytes[3 * t + t_len[t] - 1]);
        get_reply(reply, got, framed);
      join
    end
    if (t_len[t] == 3 && t_bytes[3 * t] == WRITE_OP && t_bytes[3 * t + 1] == 8'h00) begin
      reg0_model = t_bytes[3 * t + 2];
    end
    if (t_kind[t] == "glitch") begin
      if (got) begin
        record_problem(t_name[t], "a reply arrived after a short glitch on rx");
      end else begin
        record_pass(t_name[t]);
      end
    end else if (t_len[t] > 0 && !got) begin
      record_problem(t_name[t], "the reply never arrived");
    end else if (t_len[t] > 0 && !framed) begin
      record_problem(t_name[t], "the reply had a bad start or stop bit");
    end else if (t_kind[t] == "leds" && t_len[t] > 0 && reply !== ACK) begin
      record_mismatch(t_name[t], ACK, reply);
    end else if (t_kind[t] == "leds" && leds !== t_exp[t]) begin
      record_mismatch(t_name[t], t_exp[t], leds);
    end else if (t_kind[t] == "cmd" && reply !== t_exp[t]) begin
      record_mismatch(t_name[t], t_exp[t], reply);
    end else if (t_kind[t] == "cmd" && t_bytes[3 * t] == WRITE_OP && leds !== reg0_model) begin
      record_mismatch(t_name[t], reg0_model, leds);
    end else begin
      record_pass(t_name[t]);
    end
  endtask

  initial begin
    int         fd;
    string      line;
    string      nm;
    string      kd;
    int         nb;
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] ex;
    rx = 1'b1;
    reset = 1'b1;
    pass_count = 0;
    fail_count = 0;
    loaded = 1'b0;
    reg0_model = '0;
    void'($urandom(81197));
    fd = $fopen("serial_cmd_input.txt", "r");
    if (fd == 0) begin
      $display("could not open serial_cmd_input.txt");
      fail_count++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.substr(0, 0) != "#") begin
          if ($sscanf(line, "%s %s %d %h %h %h %h", nm, kd, nb, b0, b1, b2, ex) == 7
              && nb >= 0 && nb <= 3) begin
            t_name.push_back(nm);
            t_kind.push_back(kd);
            t_len.push_back(nb);
            t_bytes.push_back(b0);
            t_bytes.push_back(b1);
            t_bytes.push_back(b2);
            t_exp.push_back(ex);
          end else begin
            $display("a line of the input file could not be read and was skipped");
          end
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    wait_cycles(BIT_CLKS);
    for (int t = 0; t < t_name.size(); t++) begin
      run_test(t);
    end
    if (uut.u_sva.assert_fails != 0) begin
      $display("%0d assertion failures were reported", uut.u_sva.assert_fails);
      fail_count++;
    end
    $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Allows 60 bit times per test.
  initial begin
    wait (loaded);
    repeat ((t_name.size() * 60 + 5) * BIT_CLKS) @(posedge clk);
    $display("simulation timed out");
    $display("Done: errors found");
    $finish;
  end

endmodule

/* serial_cmd_top.sv */
`timescale 1ns/1ps

module serial_cmd_top #(
  parameter int CLK_FREQ  = 100_000_000,
  parameter int BAUD_RATE = 9600,
  parameter int REG_COUNT = 8  // At most 256.
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       rx,
  output logic       tx,
  output logic [7:0] leds
);

  import serial_cmd_pkg::*;

  logic       rx_valid;
  logic [7:0] rx_byte;
  logic       cmd_valid;
  cmd_t       cmd;
  logic       addr_err;
  logic       result_valid;
  result_t    result;
  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_busy;

  uart_rx #(
    .CLK_FREQ (CLK_FREQ),
    .BAUD_RATE(BAUD_RATE)
  ) u_rx (
    .clk     (clk),
    .reset   (reset),
    .rx      (rx),
    .rx_valid(rx_valid),
    .rx_byte (rx_byte)
  );

  cmd_decoder #(
    .REG_COUNT(REG_COUNT)
  ) u_dec (
    .clk      (clk),
    .reset    (reset),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .cmd_valid(cmd_valid),
    .cmd      (cmd),
    .addr_err (addr_err)
  );

  reg_file_exec #(
    .REG_COUNT(REG_COUNT)
  ) u_exec (
    .clk         (clk),
    .reset       (reset),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .addr_err    (addr_err),
    .result_valid(result_valid),
    .result      (result),
    .leds        (leds)
  );

  resp_builder u_resp (
    .clk         (clk),
    .reset       (reset),
    .result_valid(result_valid),
    .result      (result),
    .tx_busy     (tx_busy),
    .tx_start    (tx_start),
    .tx_byte     (tx_byte)
  );

  uart_tx #(
    .CLK_FREQ (CLK_FREQ),
    .BAUD_RATE(BAUD_RATE)
  ) u_tx (
    .clk     (clk),
    .reset   (reset),
    .tx_start(tx_start),
    .tx_byte (tx_byte),
    .tx      (tx),
    .busy    (tx_busy)
  );

endmodule

/* uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLK_FREQ  = 100_000_000,
  parameter int BAUD_RATE = 9600
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       rx,
  output logic       rx_valid,
  output logic [7:0] rx_byte
);

  localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
  localparam int CW = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CW-1:0] HALF_BIT = CW'(CLKS_PER_BIT / 2);
  localparam logic [CW-1:0] FULL_BIT = CW'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {
    s_idle,
    s_start,
    s_data,
    s_stop
  } state_t;

  state_t        state;
  logic [CW-1:0] clk_cnt;
  logic [2:0]    bit_idx;
  logic [7:0]    shift_reg;
  logic          rx_meta;
  logic          rx_sync;
  logic          bit_done;

  assign bit_done = (clk_cnt == FULL_BIT);

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_meta <= 1'b1;  // Line idles high.
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= s_idle;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        s_idle: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (!rx_sync) begin
            state <= s_start;
          end
        end
        s_start: begin
          if (clk_cnt == HALF_BIT) begin
            clk_cnt <= '0;
            state   <= rx_sync ? s_idle : s_data;  // A high midpoint was only a glitch.
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        s_data: begin
          if (bit_done) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= s_stop;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          if (bit_done) begin
            state    <= s_idle;
            rx_valid <= 1'b1;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == s_data && bit_done) begin
      shift_reg[bit_idx] <= rx_sync;  // LSB arrives first.
    end
    if (state == s_stop && bit_done) begin
      rx_byte <= shift_reg;
    end
  end

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLK_FREQ  = 100_000_000,
  parameter int BAUD_RATE = 9600
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       busy
);

  localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
  localparam int CW = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CW-1:0] FULL_BIT = CW'(CLKS_PER_BIT - 1);

  logic [CW-1:0] clk_cnt;
  logic [3:0]    bit_cnt;
  logic [8:0]    shift_reg;
  logic          bit_done;

  assign bit_done = (clk_cnt == FULL_BIT);

  always_ff @(posedge clk) begin
    if (reset) begin
      tx      <= 1'b1;
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      clk_cnt <= '0;
      bit_cnt <= '0;
      if (tx_start) begin
        busy <= 1'b1;
        tx   <= 1'b0;  // Start bit.
      end
    end else if (bit_done) begin
      clk_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;  // Stop bit has run its full period.
      end else begin
        tx      <= shift_reg[0];
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // The stop bit rides above the data and ones fill in behind it.
  always_ff @(posedge clk) begin
    if (!busy && tx_start) begin
      shift_reg <= {1'b1, tx_byte};
    end else if (busy && bit_done) begin
      shift_reg <= {1'b1, shift_reg[8:1]};
    end
  end

endmodule
